// ==== design/rv_byte_seq_pkg.sv ====
package rv_byte_seq_pkg;

  // sequencer phase driven out as cpu_state
  typedef enum logic [1:0] {
    PH_IDLE  = 2'd0,                  // run low or just out of reset
    PH_FETCH = 2'd1,                  // four instruction bytes
    PH_EXEC  = 2'd2                   // per-class execute stages
  } phase_e;

  // next address choice for the address register
  typedef enum logic [1:0] {
    AD_INIT = 2'd0,                   // start address
    AD_INC  = 2'd1,                   // next byte
    AD_PC   = 2'd2,                   // rf_pc_in from the register file
    AD_HOLD = 2'd3                    // keep current address
  } ad_sel_e;

  typedef logic [1:0] lane_t;         // byte lane where 0 is bits 7:0
  typedef logic [2:0] stg_t;          // fetch and execute stage counter

  // per-cycle control from the FSM to the datapath
  typedef struct packed {
    ad_sel_e ad_sel;                  // next address source
    logic    instr_we;                // capture rd into instr
    lane_t   instr_lane;              // instr byte to write
    logic    rmem_we;                 // capture rd into rmem
    lane_t   rmem_lane;               // rmem byte to write
    logic    rmem_clr;                // zero rmem before a load
    logic    we;                      // memory write strobe
    lane_t   wd_lane;                 // temp byte driven on wd
  } seq_ctrl_t;

  // instruction word filled bytewise and decoded by fields
  typedef struct packed {
    logic [16:0] upper;               // rs1, rs2 and imm bits
    logic [2:0]  funct3;              // access width and sign
    logic [4:0]  dest;                // rd index not used by the sequencer
    logic [6:0]  opcode;              // major opcode
  } instr_fields_t;

  typedef union packed {
    logic [3:0][7:0] bytes;           // gatherer view
    instr_fields_t   fields;          // decoder view
  } instr_word_u;

  // opcodes handled by the sequencer
  localparam logic [6:0] OP_JALR   = 7'b1100111;
  localparam logic [6:0] OP_BRANCH = 7'b1100011;
  localparam logic [6:0] OP_LOAD   = 7'b0000011;
  localparam logic [6:0] OP_STORE  = 7'b0100011;
  localparam logic [6:0] OP_CEDE   = 7'b0000000; // core yields while this sits in exec

  // load and store widths
  localparam logic [2:0] F3_B  = 3'b000;
  localparam logic [2:0] F3_H  = 3'b001;
  localparam logic [2:0] F3_W  = 3'b010;
  localparam logic [2:0] F3_BU = 3'b100;
  localparam logic [2:0] F3_HU = 3'b101;

endpackage

// ==== design/seq_ctrl.sv ====
`timescale 1ns/10ps

module seq_ctrl import rv_byte_seq_pkg::*; (
  input  logic        clk,
  input  logic        rmem_rst,
  input  logic        run,
  input  instr_word_u instr,
  output seq_ctrl_t   ctrl,
  output phase_e      cpu_state,
  output stg_t        instr_stg,
  output logic        cede
);

  phase_e phase;                      // current phase
  phase_e phase_n;
  stg_t   fetch_stg;                  // 0 to 4 in fetch
  stg_t   fetch_stg_n;
  stg_t   exec_stg;                   // stage within execute
  stg_t   exec_stg_n;

  logic       op_ld;                  // listed load width
  logic       op_st;                  // listed store width
  logic       op_cede;                // all-zero opcode
  logic       ld_wait;                // wait stage before the first byte
  logic [2:0] xfer_n;                 // bytes moved, 1 2 or 4
  stg_t       exec_last;              // final execute stage

  // opcode and funct3 decode into length and width
  always_comb begin
    op_ld     = 1'b0;
    op_st     = 1'b0;
    op_cede   = 1'b0;
    ld_wait   = 1'b0;
    xfer_n    = 3'd1;
    exec_last = 3'd0;                 // unknown ops take one cycle
    case (instr.fields.opcode)
      OP_JALR: begin
        exec_last = 3'd2;             // 3 cycles
      end
      OP_BRANCH: begin
        exec_last = 3'd1;             // flags then new pc
      end
      OP_LOAD: begin
        case (instr.fields.funct3)
          F3_B: begin
            op_ld     = 1'b1;
            exec_last = 3'd5;         // extra stage kept for the sign extend slot
          end
          F3_BU: begin
            op_ld     = 1'b1;
            exec_last = 3'd4;
          end
          F3_H: begin
            op_ld     = 1'b1;
            ld_wait   = 1'b1;
            xfer_n    = 3'd2;
            exec_last = 3'd6;         // also keeps the sign extend slot
          end
          F3_HU: begin
            op_ld     = 1'b1;
            ld_wait   = 1'b1;
            xfer_n    = 3'd2;
            exec_last = 3'd5;
          end
          F3_W: begin
            op_ld     = 1'b1;
            ld_wait   = 1'b1;
            xfer_n    = 3'd4;
            exec_last = 3'd7;
          end
          default: exec_last = 3'd0;  // unlisted width, one cycle
        endcase
      end
      OP_STORE: begin
        case (instr.fields.funct3)
          F3_B: begin
            op_st     = 1'b1;
            exec_last = 3'd2;
          end
          F3_H: begin
            op_st     = 1'b1;
            xfer_n    = 3'd2;
            exec_last = 3'd3;
          end
          F3_W: begin
            op_st     = 1'b1;
            xfer_n    = 3'd4;
            exec_last = 3'd5;
          end
          default: exec_last = 3'd0;
        endcase
      end
      OP_CEDE: begin
        op_cede = 1'b1;               // parks in execute
      end
      default: exec_last = 3'd0;
    endcase
  end

  // next state and per-stage control
  always_comb begin
    phase_n     = phase;
    fetch_stg_n = fetch_stg;
    exec_stg_n  = exec_stg;
    ctrl        = '0;
    ctrl.ad_sel = AD_HOLD;            // address holds unless told otherwise
    cede        = 1'b0;
    if (!run) begin
      phase_n     = PH_IDLE;          // ad holds while stopped
      fetch_stg_n = '0;
      exec_stg_n  = '0;
    end else begin
      case (phase)
        PH_IDLE: begin
          phase_n     = PH_FETCH;
          ctrl.ad_sel = AD_INIT;      // fetch starts at the init address
        end
        PH_FETCH: begin
          fetch_stg_n = stg_t'(fetch_stg + 3'd1);
          if (fetch_stg != 3'd0) begin
            ctrl.instr_we   = 1'b1;   // rd lags ad by one cycle
            ctrl.instr_lane = lane_t'(fetch_stg - 3'd1);
          end
          if (fetch_stg == 3'd4) begin
            fetch_stg_n = '0;         // last byte, hold ad
            phase_n     = PH_EXEC;
          end else begin
            ctrl.ad_sel = AD_INC;
          end
        end
        PH_EXEC: begin
          if (op_cede) begin
            cede = 1'b1;              // stays here until run drops
          end else begin
            exec_stg_n = stg_t'(exec_stg + 3'd1);
            if (op_ld) begin
              if (exec_stg == 3'd0) begin
                ctrl.rmem_clr = 1'b1; // narrow loads come out zero filled
                ctrl.ad_sel   = AD_PC;
              end
              if (exec_stg == 3'd2 && ld_wait) begin
                ctrl.ad_sel = AD_INC; // step while first byte is in flight
              end
              if (exec_stg >= 3'd3 && (exec_stg - 3'd3) < xfer_n) begin
                ctrl.rmem_we   = 1'b1;
                ctrl.rmem_lane = lane_t'(exec_stg - 3'd3);
                if ((exec_stg - 3'd1) < xfer_n) begin
                  ctrl.ad_sel = AD_INC; // word only, two bytes still to ask for
                end
              end
            end
            if (op_st) begin
              if (exec_stg == 3'd1) begin
                ctrl.ad_sel = AD_PC;  // store address
              end
              if (exec_stg >= 3'd2) begin
                ctrl.we      = 1'b1;
                ctrl.wd_lane = lane_t'(exec_stg - 3'd2);
                ctrl.ad_sel  = AD_INC;
              end
            end
            if (exec_stg == exec_last) begin
              ctrl.ad_sel = AD_PC;    // redirect to next pc
              exec_stg_n  = '0;
              phase_n     = PH_FETCH;
            end
          end
        end
        default: begin
          phase_n = PH_IDLE;          // unused encoding
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (rmem_rst) begin
      phase     <= PH_IDLE;
      fetch_stg <= '0;
      exec_stg  <= '0;
    end else begin
      phase     <= phase_n;
      fetch_stg <= fetch_stg_n;
      exec_stg  <= exec_stg_n;
    end
  end

  assign cpu_state = phase;
  assign instr_stg = exec_stg;        // fetch stage stays internal

endmodule

// ==== design/mem_port.sv ====
`timescale 1ns/10ps

module mem_port import rv_byte_seq_pkg::*; #(
  parameter int              MABL      = 19,
  parameter logic [MABL-1:0] INIT_ADDR = '0
) (
  input  logic            clk,
  input  logic            rmem_rst,
  input  seq_ctrl_t       ctrl,
  input  logic [31:0]     rf_pc_in,
  input  logic [31:0]     temp,
  output logic [MABL-1:0] ad,
  output logic            we,
  output logic [7:0]      wd
);

  logic [MABL-1:0] ad_n;              // next address

  // four-way next address
  always_comb begin
    case (ctrl.ad_sel)
      AD_INIT: ad_n = INIT_ADDR;
      AD_INC:  ad_n = ad + 1'b1;      // byte step
      AD_PC:   ad_n = rf_pc_in[MABL-1:0]; // pc or load/store address
      default: ad_n = ad;             // hold
    endcase
  end

  always_ff @(posedge clk) begin
    if (rmem_rst) begin
      ad <= INIT_ADDR;
    end else begin
      ad <= ad_n;
    end
  end

  // store byte of temp for the current lane
  always_comb begin
    case (ctrl.wd_lane)
      2'd0:    wd = temp[7:0];
      2'd1:    wd = temp[15:8];
      2'd2:    wd = temp[23:16];
      default: wd = temp[31:24];
    endcase
  end

  assign we = ctrl.we;                // write lands at current ad

endmodule

// ==== design/byte_gather.sv ====
`timescale 1ns/10ps

module byte_gather import rv_byte_seq_pkg::*; (
  input  logic        clk,
  input  logic        rmem_rst,
  input  seq_ctrl_t   ctrl,
  input  logic [7:0]  rd,
  output instr_word_u instr,
  output logic [31:0] rmem
);

  logic [3:0][7:0] ld_q;              // load data, one lane per byte

  // instruction word, lane by lane during fetch
  always_ff @(posedge clk) begin
    if (rmem_rst) begin
      instr <= '0;
    end else if (ctrl.instr_we) begin
      instr.bytes[ctrl.instr_lane] <= rd; // little endian fill
    end
  end

  // load data
  always_ff @(posedge clk) begin
    if (rmem_rst) begin
      ld_q <= '0;
    end else if (ctrl.rmem_clr) begin
      ld_q <= '0;                     // upper lanes stay zero for lb and lh
    end else if (ctrl.rmem_we) begin
      ld_q[ctrl.rmem_lane] <= rd;
    end
  end

  assign rmem = ld_q;                 // sign extension happens in the register file

endmodule

// ==== design/rv_byte_seq.sv ====
`timescale 1ns/10ps

module rv_byte_seq import rv_byte_seq_pkg::*; #(
  parameter int              MABL      = 19,
  parameter logic [MABL-1:0] INIT_ADDR = '0
) (
  input  logic            clk,
  input  logic            rmem_rst,
  input  logic            run,
  input  logic [31:0]     rf_pc_in,   // next pc, or load/store address
  input  logic [31:0]     temp,       // store source
  input  logic [7:0]      rd,
  output logic [MABL-1:0] ad,
  output logic            we,
  output logic [7:0]      wd,
  output logic [31:0]     instr,
  output logic [31:0]     rmem,
  output logic            cede,
  output phase_e          cpu_state,
  output stg_t            instr_stg
);

  seq_ctrl_t   ctrl;                  // FSM to datapath
  instr_word_u instr_w;               // fetched word back to the decoder

  seq_ctrl u_seq_ctrl (
    .clk       (clk),
    .rmem_rst  (rmem_rst),
    .run       (run),
    .instr     (instr_w),
    .ctrl      (ctrl),
    .cpu_state (cpu_state),
    .instr_stg (instr_stg),
    .cede      (cede)
  );

  mem_port #(
    .MABL      (MABL),
    .INIT_ADDR (INIT_ADDR)
  ) u_mem_port (
    .clk      (clk),
    .rmem_rst (rmem_rst),
    .ctrl     (ctrl),
    .rf_pc_in (rf_pc_in),
    .temp     (temp),
    .ad       (ad),
    .we       (we),
    .wd       (wd)
  );

  byte_gather u_byte_gather (
    .clk      (clk),
    .rmem_rst (rmem_rst),
    .ctrl     (ctrl),
    .rd       (rd),
    .instr    (instr_w),
    .rmem     (rmem)
  );

  assign instr = instr_w;             // flat 32 bits for the core

endmodule

// ==== verif/rv_byte_seq_props.sv ====
`timescale 1ns/10ps

module rv_byte_seq_props import rv_byte_seq_pkg::*; (
  input logic        clk,
  input logic        rmem_rst,
  input logic        run,
  input logic        we,
  input logic        cede,
  input logic [31:0] instr,
  input phase_e      cpu_state,
  input stg_t        instr_stg
);

  // memory writes only from store stages
  a_we_exec: assert property (@(posedge clk) disable iff (rmem_rst)
    we |-> cpu_state == PH_EXEC)
    else $error("we high outside execute");

  a_cede_op: assert property (@(posedge clk) disable iff (rmem_rst)
    cede |-> (cpu_state == PH_EXEC && instr[6:0] == 7'd0))
    else $error("cede without a zero opcode in execute");

  a_stg_idle: assert property (@(posedge clk) disable iff (rmem_rst)
    cpu_state != PH_EXEC |-> instr_stg == '0)
    else $error("exec stage nonzero outside execute");

  // first fetch cycle plus four more, then out
  a_fetch_len: assert property (@(posedge clk) disable iff (rmem_rst || !run)
    (cpu_state == PH_FETCH && $past(cpu_state) != PH_FETCH) |=>
      cpu_state == PH_FETCH ##1 cpu_state == PH_FETCH ##1 cpu_state == PH_FETCH
      ##1 cpu_state == PH_FETCH ##1 cpu_state != PH_FETCH)
    else $error("fetch did not last five cycles");

endmodule

bind rv_byte_seq rv_byte_seq_props u_props (
  .clk       (clk),
  .rmem_rst  (rmem_rst),
  .run       (run),
  .we        (we),
  .cede      (cede),
  .instr     (instr),
  .cpu_state (cpu_state),
  .instr_stg (instr_stg)
);

// ==== verif/rv_byte_seq_tb.sv ====
`timescale 1ns/10ps

module rv_byte_seq_tb import rv_byte_seq_pkg::*;;

  localparam int              MABL = 19;
  localparam logic [MABL-1:0] INIT = 19'h00200;   // nonzero start address
  localparam int              NI   = 13;          // instructions before the cede word

  logic            clk;
  logic            rmem_rst;
  logic            run;
  logic [31:0]     rf_pc_in;
  logic [31:0]     temp;
  logic [7:0]      rd;
  logic [MABL-1:0] ad;
  logic            we;
  logic [7:0]      wd;
  logic [31:0]     instr;
  logic [31:0]     rmem;
  logic            cede;
  phase_e          cpu_state;
  stg_t            instr_stg;

  logic [7:0]      mem [0:(1<<MABL)-1];           // byte memory model
  logic [6:0]      op_l   [0:NI];
  logic [2:0]      f3_l   [0:NI];
  logic [MABL-1:0] pc_l   [0:NI];                 // where each instruction sits
  logic [MABL-1:0] dat_l  [0:NI];                 // load or store address
  logic [31:0]     word_l [0:NI];
  logic [31:0]     tval   [0:NI];                 // temp per instruction
  stg_t            last_l [0:NI];                 // last exec stage per the reference
  int              cur;                           // instruction now running
  logic            run_req;
  int              errors;
  int              timeouts;

  rv_byte_seq #(
    .MABL      (MABL),
    .INIT_ADDR (INIT)
  ) DUT (
    .clk       (clk),
    .rmem_rst  (rmem_rst),
    .run       (run),
    .rf_pc_in  (rf_pc_in),
    .temp      (temp),
    .rd        (rd),
    .ad        (ad),
    .we        (we),
    .wd        (wd),
    .instr     (instr),
    .rmem      (rmem),
    .cede      (cede),
    .cpu_state (cpu_state),
    .instr_stg (instr_stg)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;                        // 8 ns period
  end

  // synchronous memory sampled mid cycle and answered just after the edge
  always begin : mem_model
    logic [MABL-1:0] a;
    logic            w;
    logic [7:0]      d;
    @(negedge clk);
    a = ad;
    w = we;
    d = wd;
    @(posedge clk);
    #1;
    rd = mem[a];                                  // old byte when read and write collide
    if (w) begin
      mem[a] = d;
    end
  end

  // scripted rf_pc_in, temp and run
  always @(posedge clk) begin
    #1;
    run  = run_req;
    temp = tval[cur];
    if (cpu_state == PH_EXEC && instr_stg == last_l[cur]) begin
      rf_pc_in = {13'h0a5, pc_l[cur + 1 > NI ? NI : cur + 1]}; // upper bits must be dropped
    end else begin
      rf_pc_in = {13'h15a, dat_l[cur]};
    end
  end

  // exec length and bytes moved from the class table
  function automatic int ref_exec(input logic [6:0] op, input logic [2:0] f3,
                                  output int nbytes, output int kind);
    int len;
    len  = 1;                                     // other classes
    kind = 0;                                     // 1 load, 2 store, 3 cede
    case (op)
      7'b1100111: len = 3;
      7'b1100011: len = 2;
      7'b0000011: begin
        case (f3)
          3'b000:  len = 6;
          3'b100:  len = 5;
          3'b001:  len = 7;
          3'b101:  len = 6;
          3'b010:  len = 8;
          default: len = 1;                       // unlisted width
        endcase
        kind = (len > 1) ? 1 : 0;
      end
      7'b0100011: begin
        case (f3)
          3'b000:  len = 3;
          3'b001:  len = 4;
          3'b010:  len = 6;
          default: len = 1;
        endcase
        kind = (len > 1) ? 2 : 0;
      end
      7'b0000000: begin
        len  = 0;                                 // never leaves exec
        kind = 3;
      end
      default: len = 1;
    endcase
    nbytes = (kind == 1 || kind == 2) ? (f3[1] ? 4 : (f3[0] ? 2 : 1)) : 0; // width field
    return len;
  endfunction

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      errors++;
      $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  // wait at negedges for a phase
  task automatic wait_for_phase(input phase_e p, input string what);
    int n;
    n = 0;
    while (cpu_state != p && n < 200) begin
      @(negedge clk);
      n++;
    end
    if (cpu_state != p) begin
      timeouts++;
      $display("Timeout at %0t: the sequencer never reached %s", $time, what);
    end
  endtask

  // cycles spent in phase p counted from the current negedge
  task automatic count_cycles(input phase_e p, input int limit, output int n);
    n = 0;
    while (cpu_state == p && n <= limit) begin
      n++;
      @(negedge clk);
    end
    if (n > limit) begin
      timeouts++;
      $display("Timeout at %0t: phase %0d lasted more than %0d cycles", $time, p, limit);
    end
  endtask

  task automatic run_one(input int i);
    int          n;
    int          len;
    int          nb;
    int          kind;
    logic [31:0] exp;
    logic [7:0]  snap [0:7];
    cur = i;
    len = ref_exec(op_l[i], f3_l[i], nb, kind);
    wait_for_phase(PH_FETCH, "fetch");
    if (timeouts == 0) begin
      check("ad at fetch start", 32'(ad), 32'(pc_l[i]));
      for (int k = 0; k < 8; k++) begin
        snap[k] = mem[dat_l[i] - 2 + k];          // window around the store
      end
      count_cycles(PH_FETCH, 10, n);
      check("fetch cycles", n, 5);
    end
    if (timeouts == 0) begin
      check("instr", instr, word_l[i]);
      count_cycles(PH_EXEC, 20, n);
      check("exec cycles", n, len);
    end
    if (timeouts == 0 && kind == 1) begin
      exp = '0;
      for (int k = 0; k < nb; k++) begin
        exp[8*k +: 8] = mem[dat_l[i] + k];        // little endian and zero filled
      end
      check("rmem", rmem, exp);
    end
    if (timeouts == 0 && kind == 2) begin
      for (int k = 0; k < 8; k++) begin
        exp[7:0] = (k >= 2 && k < 2 + nb) ? tval[i][8*(k-2) +: 8] : snap[k];
        check($sformatf("mem[%h]", dat_l[i] - 2 + k), 32'(mem[dat_l[i] - 2 + k]),
              32'(exp[7:0]));
      end
    end
  endtask

  task automatic run_cede();
    logic [MABL-1:0] held;
    int              n;
    cur = NI;
    wait_for_phase(PH_FETCH, "fetch of the cede word");
    if (timeouts == 0) begin
      check("ad at fetch start", 32'(ad), 32'(pc_l[NI]));
      count_cycles(PH_FETCH, 10, n);
      check("fetch cycles", n, 5);
      check("instr", instr, 32'h0);
      held = ad;
      for (int k = 0; k < 20; k++) begin          // parked while run stays high
        check("cpu_state", 32'(cpu_state), 32'(PH_EXEC));
        check("cede", 32'(cede), 32'd1);
        check("ad while ceding", 32'(ad), 32'(held));
        @(negedge clk);
      end
      run_req = 1'b0;
      wait_for_phase(PH_IDLE, "idle after run dropped");
      if (timeouts == 0) begin
        check("ad after stop", 32'(ad), 32'(held));
        check("cede after stop", 32'(cede), 32'd0);
        check("instr_stg after stop", 32'(instr_stg), 32'd0);
      end
    end
  endtask

  task automatic finish_run();
    $display("errors %0d, timeouts %0d", errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  endtask

  initial begin : main
    int seed_v;
    int nb;
    int kind;
    seed_v   = $urandom(32'h2d3a);
    rmem_rst = 1'b1;
    run      = 1'b0;
    run_req  = 1'b0;
    rf_pc_in = '0;
    temp     = '0;
    rd       = '0;
    cur      = 0;
    errors   = 0;
    timeouts = 0;
    for (int a = 0; a < (1 << MABL); a++) begin
      mem[a] = 8'($urandom);                      // random background
    end
    // lw runs ahead of the narrow loads so their zero fill is seen
    op_l = '{OP_JALR, OP_BRANCH, OP_LOAD, OP_LOAD, OP_LOAD, OP_LOAD, OP_LOAD,
             OP_STORE, OP_STORE, OP_STORE, 7'b0110011, OP_LOAD, OP_STORE, OP_CEDE};
    f3_l = '{3'b000, 3'b001, F3_W, F3_B, F3_BU, F3_H, F3_HU,
             F3_B, F3_H, F3_W, 3'b000, 3'b011, 3'b111, 3'b000}; // alu op then unlisted widths
    for (int i = 0; i <= NI; i++) begin
      pc_l[i]   = INIT + MABL'(i * 'h44);         // spaced apart so a redirect shows
      dat_l[i]  = 19'h10000 + MABL'(i * 16) + MABL'($urandom % 4);
      tval[i]   = $urandom;
      word_l[i] = {17'($urandom), f3_l[i], 5'($urandom), op_l[i]};
      last_l[i] = stg_t'(ref_exec(op_l[i], f3_l[i], nb, kind) - 1);
    end
    word_l[NI] = '0;                              // all-zero word
    last_l[NI] = 3'd7;                            // cede never ends on its own
    for (int i = 0; i <= NI; i++) begin
      for (int k = 0; k < 4; k++) begin
        mem[pc_l[i] + MABL'(k)] = word_l[i][8*k +: 8];
      end
    end
    repeat (16) @(posedge clk);
    #1;
    rmem_rst = 1'b0;
    @(negedge clk);
    check("we after reset", 32'(we), 32'd0);
    check("cede after reset", 32'(cede), 32'd0);
    check("cpu_state after reset", 32'(cpu_state), 32'(PH_IDLE));
    check("ad after reset", 32'(ad), 32'(INIT));
    check("instr after reset", instr, 32'h0);
    check("rmem after reset", rmem, 32'h0);
    run_req = 1'b1;
    for (int i = 0; i < NI && timeouts == 0; i++) begin
      run_one(i);
    end
    if (timeouts == 0) begin
      run_cede();
    end
    finish_run();
  end

endmodule

// ==== rv_byte_seq.f ====
design/rv_byte_seq_pkg.sv
design/seq_ctrl.sv
design/mem_port.sv
design/byte_gather.sv
design/rv_byte_seq.sv
verif/rv_byte_seq_props.sv
verif/rv_byte_seq_tb.sv

// ==== Makefile ====
TOOL   ?= verilator
FLAGS  ?= --timing --assert -Wno-fatal
TOP    ?= rv_byte_seq_tb
FLIST  ?= rv_byte_seq.f
OBJDIR ?= obj_dir
LOG    ?= sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) --lint-only $(FLAGS) --top-module $(TOP) -f $(FLIST)

$(OBJDIR)/V$(TOP): $(shell cat $(FLIST))
	$(TOOL) --binary $(FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJDIR)

sim: $(OBJDIR)/V$(TOP)
	./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "^STATUS: PASS$$" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)
